//--- logic/exu_cfg_pkg.sv
package exu_cfg_pkg;

  // Condition codes produced by every unit and forwarded like data
  typedef struct packed {
    logic carry; // Carry out, or no-borrow on subtract
    logic zero;
    logic sign;
    logic ovf; // Signed overflow
  } flags_t;

  // Where an operand is taken from at the issue edge
  typedef enum logic [1:0] {
    src_port  = 2'd0,
    src_lane0 = 2'd1,
    src_lane1 = 2'd2,
    src_mul   = 2'd3
  } byp_src_t;

endpackage

//--- logic/exu_op_pkg.sv
package exu_op_pkg;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_adc = 4'd2,
    op_and = 4'd3,
    op_or  = 4'd4,
    op_xor = 4'd5,
    op_shl = 4'd6,
    op_shr = 4'd7,
    op_sar = 4'd8,
    op_mul = 4'd9
  } op_t;

  typedef enum logic [2:0] {
    fn_add = 3'd0,
    fn_sub = 3'd1,
    fn_adc = 3'd2,
    fn_and = 3'd3,
    fn_or  = 3'd4,
    fn_xor = 3'd5
  } alu_fn_t;

  typedef enum logic [1:0] {
    sh_left  = 2'd0,
    sh_right = 2'd1,
    sh_arith = 2'd2 // Right shift with sign fill
  } shift_fn_t;

  function automatic logic is_alu_op(op_t op);
    return op inside {op_add, op_sub, op_adc, op_and, op_or, op_xor};
  endfunction

  function automatic logic is_shift_op(op_t op);
    return op inside {op_shl, op_shr, op_sar};
  endfunction

  function automatic alu_fn_t alu_fn_of(op_t op);
    case (op)
      op_sub:  return fn_sub;
      op_adc:  return fn_adc;
      op_and:  return fn_and;
      op_or:   return fn_or;
      op_xor:  return fn_xor;
      default: return fn_add;
    endcase
  endfunction

  function automatic shift_fn_t shift_fn_of(op_t op);
    case (op)
      op_shr:  return sh_right;
      op_sar:  return sh_arith;
      default: return sh_left;
    endcase
  endfunction

endpackage

//--- logic/operand_bypass.sv
module operand_bypass import exu_cfg_pkg::*; #(
  parameter type payload_t = logic [63:0]
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     capture,
  input  byp_src_t src,
  input  payload_t port_val,
  input  payload_t lane0_val,
  input  payload_t lane1_val,
  input  payload_t mul_val,
  output payload_t operand
);

  // The buses are the output registers of the units, so whatever they
  // hold at the issue edge is the value the operation sees
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      operand <= '0;
    end else if (capture) begin
      case (src)
        src_lane0: operand <= lane0_val;
        src_lane1: operand <= lane1_val;
        src_mul:   operand <= mul_val;
        default:   operand <= port_val;
      endcase
    end
  end

  a_src_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    capture |-> !$isunknown(src)
  ) else $error("operand_bypass: forwarding source unknown at capture");

endmodule

//--- logic/barrel_shifter.sv
module barrel_shifter import exu_cfg_pkg::*; import exu_op_pkg::*; #(
  parameter int data_w = 64
) (
  input  shift_fn_t                   kind,
  input  logic [data_w-1:0]           value,
  input  logic [$clog2(data_w)-1:0]   amount,
  output logic [data_w-1:0]           res,
  output flags_t                      flags
);

  localparam int sh_w = $clog2(data_w);

  logic [data_w-1:0] stage [sh_w+1];
  logic [data_w-1:0] rev_in;
  logic [data_w-1:0] rev_out;
  logic              fill;

  // A left shift is a right shift of the bit-reversed value
  always_comb begin
    for (int i = 0; i < data_w; i++) begin
      rev_in[i]  = value[data_w-1-i];
      rev_out[i] = stage[sh_w][data_w-1-i];
    end
  end

  assign fill     = (kind == sh_arith) & value[data_w-1];
  assign stage[0] = (kind == sh_left) ? rev_in : value;

  for (genvar i = 0; i < sh_w; i++) begin : g_stage
    assign stage[i+1] = amount[i] ?
      {{(2**i){fill}}, stage[i][data_w-1:2**i]} : stage[i]; // Stage i moves by 2**i
  end

  assign res = (kind == sh_left) ? rev_out : stage[sh_w];

  assign flags.carry = 1'b0;
  assign flags.zero  = ~|res;
  assign flags.sign  = res[data_w-1];
  assign flags.ovf   = 1'b0;

endmodule

//--- logic/int_alu.sv
module int_alu import exu_cfg_pkg::*; import exu_op_pkg::*; #(
  parameter int data_w    = 64,
  parameter bit has_shift = 1'b0
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              load,
  input  alu_fn_t           fn,
  input  shift_fn_t         shift_fn,
  input  logic              use_shift,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  flags_t            flags_in,
  output logic [data_w-1:0] res,
  output flags_t            flags
);

  localparam int sh_w = $clog2(data_w);

  logic [data_w-1:0] b_eff;
  logic [data_w-1:0] sum;
  logic              carry_out;
  logic              cin;
  logic [data_w-1:0] sh_res;
  flags_t            sh_flags;
  logic [data_w-1:0] nxt_res;
  flags_t            nxt_flags;

  if (has_shift) begin : g_shift
    barrel_shifter #(.data_w(data_w)) u_shifter (
      .kind   (shift_fn),
      .value  (a),
      .amount (b[sh_w-1:0]),
      .res    (sh_res),
      .flags  (sh_flags)
    );
  end else begin : g_no_shift
    assign sh_res   = '0;
    assign sh_flags = '0;
  end

  // Subtract is a + ~b + 1, so carry set means no borrow
  assign b_eff = (fn == fn_sub) ? ~b : b;
  assign cin   = (fn == fn_sub) | ((fn == fn_adc) & flags_in.carry);
  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_eff} + {{data_w{1'b0}}, cin};

  always_comb begin
    nxt_flags = '0;
    case (fn)
      fn_and:  nxt_res = a & b;
      fn_or:   nxt_res = a | b;
      fn_xor:  nxt_res = a ^ b;
      default: begin
        nxt_res         = sum;
        nxt_flags.carry = carry_out;
        nxt_flags.ovf   = (a[data_w-1] == b_eff[data_w-1]) & (sum[data_w-1] != a[data_w-1]);
      end
    endcase
    nxt_flags.zero = ~|nxt_res;
    nxt_flags.sign = nxt_res[data_w-1];
    if (use_shift) begin
      nxt_res   = sh_res;
      nxt_flags = sh_flags;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res   <= '0;
      flags <= '0;
    end else if (load) begin
      res   <= nxt_res;
      flags <= nxt_flags;
    end
  end

  a_shift_present: assert property (
    @(posedge clk) disable iff (!arst_n)
    load && use_shift |-> has_shift
  ) else $error("int_alu: shift requested on a lane without a shifter");

endmodule

//--- logic/pipe_multiplier.sv
module pipe_multiplier import exu_cfg_pkg::*; #(
  parameter int data_w = 64
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              flush,
  input  logic              start,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  output logic [data_w-1:0] res,
  output flags_t            flags,
  output logic              valid
);

  localparam int half_w = data_w / 2;

  logic [half_w-1:0] a_lo, a_hi, b_lo, b_hi;
  logic [data_w-1:0] pp_ll;
  logic [half_w-1:0] pp_hl, pp_lh; // Only the low half of the cross terms reaches the result
  logic [data_w-1:0] sum_q;
  logic              v1, v2;

  assign {a_hi, a_lo} = a;
  assign {b_hi, b_lo} = b;

  always_ff @(posedge clk) begin
    if (start) begin
      pp_ll <= {{half_w{1'b0}}, a_lo} * {{half_w{1'b0}}, b_lo};
      pp_hl <= a_hi * b_lo;
      pp_lh <= a_lo * b_hi;
    end
    if (v1) begin
      sum_q <= pp_ll + {pp_hl + pp_lh, {half_w{1'b0}}};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1    <= 1'b0;
      v2    <= 1'b0;
      valid <= 1'b0;
      res   <= '0;
      flags <= '0;
    end else begin
      v1    <= start & ~flush;
      v2    <= v1 & ~flush;
      valid <= v2 & ~flush;
      if (v2 && !flush) begin // Bus holds its last product otherwise
        res   <= sum_q;
        flags <= '{carry: 1'b0, zero: ~|sum_q, sign: sum_q[data_w-1], ovf: 1'b0};
      end
    end
  end

endmodule

//--- logic/exu_control.sv
module exu_control import exu_op_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      flush,
  input  logic      lane0_valid,
  input  op_t       lane0_op,
  input  logic      lane1_valid,
  input  op_t       lane1_op,
  output alu_fn_t   lane0_fn,
  output alu_fn_t   lane1_fn,
  output shift_fn_t lane1_shift_fn,
  output logic      lane1_use_shift,
  output logic      lane0_load,
  output logic      lane1_load,
  output logic      mul_start,
  output logic      lane0_res_valid,
  output logic      lane1_res_valid
);

  logic lane0_v_q;
  logic lane1_v_q;
  op_t  lane0_op_q;
  op_t  lane1_op_q;
  logic lane0_legal;
  logic lane1_legal;

  // Issue register, sampled on the same edge as the operand bypasses
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane0_v_q  <= 1'b0;
      lane1_v_q  <= 1'b0;
      lane0_op_q <= op_add;
      lane1_op_q <= op_add;
    end else begin
      lane0_v_q  <= lane0_valid & ~flush; // Issue on a flush edge is dropped
      lane1_v_q  <= lane1_valid & ~flush;
      lane0_op_q <= lane0_op;
      lane1_op_q <= lane1_op;
    end
  end

  assign lane0_legal = is_alu_op(lane0_op_q);
  assign lane1_legal = is_alu_op(lane1_op_q) | is_shift_op(lane1_op_q);

  assign lane0_fn        = alu_fn_of(lane0_op_q);
  assign lane1_fn        = alu_fn_of(lane1_op_q);
  assign lane1_shift_fn  = shift_fn_of(lane1_op_q);
  assign lane1_use_shift = is_shift_op(lane1_op_q);

  // A flush in the execute cycle still stops the write to the bus
  assign lane0_load = lane0_v_q & lane0_legal & ~flush;
  assign lane1_load = lane1_v_q & lane1_legal & ~flush;
  assign mul_start  = lane1_v_q & (lane1_op_q == op_mul) & ~flush;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane0_res_valid <= 1'b0;
      lane1_res_valid <= 1'b0;
    end else begin
      lane0_res_valid <= lane0_load;
      lane1_res_valid <= lane1_load;
    end
  end

  a_lane0_legal: assert property (
    @(posedge clk) disable iff (!arst_n)
    lane0_valid && !flush |=> lane0_load || flush
  ) else $error("exu_control: lane 0 was issued a shift or multiply");

endmodule

//--- logic/exu_cluster.sv
module exu_cluster import exu_cfg_pkg::*; import exu_op_pkg::*; #(
  parameter int data_w = 64
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              flush,
  input  logic              lane0_valid,
  input  op_t               lane0_op,
  input  logic [data_w-1:0] lane0_a,
  input  logic [data_w-1:0] lane0_b,
  input  flags_t            lane0_flags_in,
  input  byp_src_t          lane0_a_src,
  input  byp_src_t          lane0_b_src,
  input  byp_src_t          lane0_f_src,
  input  logic              lane1_valid,
  input  op_t               lane1_op,
  input  logic [data_w-1:0] lane1_a,
  input  logic [data_w-1:0] lane1_b,
  input  flags_t            lane1_flags_in,
  input  byp_src_t          lane1_a_src,
  input  byp_src_t          lane1_b_src,
  input  byp_src_t          lane1_f_src,
  output logic [data_w-1:0] lane0_res,
  output flags_t            lane0_flags,
  output logic              lane0_res_valid,
  output logic [data_w-1:0] lane1_res,
  output flags_t            lane1_flags,
  output logic              lane1_res_valid,
  output logic [data_w-1:0] mul_res,
  output flags_t            mul_flags,
  output logic              mul_valid
);

  logic [data_w-1:0] l0_a, l0_b, l1_a, l1_b;
  flags_t            l0_f, l1_f;
  alu_fn_t           lane0_fn, lane1_fn;
  shift_fn_t         lane1_shift_fn;
  logic              lane1_use_shift;
  logic              lane0_load, lane1_load, mul_start;

  operand_bypass #(.payload_t(logic [data_w-1:0])) u_l0_a (.clk, .arst_n,
    .capture(lane0_valid), .src(lane0_a_src), .port_val(lane0_a), .lane0_val(lane0_res),
    .lane1_val(lane1_res), .mul_val(mul_res), .operand(l0_a));
  operand_bypass #(.payload_t(logic [data_w-1:0])) u_l0_b (.clk, .arst_n,
    .capture(lane0_valid), .src(lane0_b_src), .port_val(lane0_b), .lane0_val(lane0_res),
    .lane1_val(lane1_res), .mul_val(mul_res), .operand(l0_b));
  operand_bypass #(.payload_t(flags_t)) u_l0_f (.clk, .arst_n,
    .capture(lane0_valid), .src(lane0_f_src), .port_val(lane0_flags_in),
    .lane0_val(lane0_flags), .lane1_val(lane1_flags), .mul_val(mul_flags), .operand(l0_f));
  operand_bypass #(.payload_t(logic [data_w-1:0])) u_l1_a (.clk, .arst_n,
    .capture(lane1_valid), .src(lane1_a_src), .port_val(lane1_a), .lane0_val(lane0_res),
    .lane1_val(lane1_res), .mul_val(mul_res), .operand(l1_a));
  operand_bypass #(.payload_t(logic [data_w-1:0])) u_l1_b (.clk, .arst_n,
    .capture(lane1_valid), .src(lane1_b_src), .port_val(lane1_b), .lane0_val(lane0_res),
    .lane1_val(lane1_res), .mul_val(mul_res), .operand(l1_b));
  operand_bypass #(.payload_t(flags_t)) u_l1_f (.clk, .arst_n,
    .capture(lane1_valid), .src(lane1_f_src), .port_val(lane1_flags_in),
    .lane0_val(lane0_flags), .lane1_val(lane1_flags), .mul_val(mul_flags), .operand(l1_f));

  exu_control u_control (.clk, .arst_n, .flush, .lane0_valid, .lane0_op, .lane1_valid,
    .lane1_op, .lane0_fn, .lane1_fn, .lane1_shift_fn, .lane1_use_shift, .lane0_load,
    .lane1_load, .mul_start, .lane0_res_valid, .lane1_res_valid);

  // Lane 0 has no shifter, so its shift controls are tied off
  int_alu #(.data_w(data_w), .has_shift(1'b0)) u_alu0 (.clk, .arst_n, .load(lane0_load),
    .fn(lane0_fn), .shift_fn(sh_left), .use_shift(1'b0), .a(l0_a), .b(l0_b),
    .flags_in(l0_f), .res(lane0_res), .flags(lane0_flags));
  int_alu #(.data_w(data_w), .has_shift(1'b1)) u_alu1 (.clk, .arst_n, .load(lane1_load),
    .fn(lane1_fn), .shift_fn(lane1_shift_fn), .use_shift(lane1_use_shift), .a(l1_a),
    .b(l1_b), .flags_in(l1_f), .res(lane1_res), .flags(lane1_flags));

  pipe_multiplier #(.data_w(data_w)) u_mul (.clk, .arst_n, .flush, .start(mul_start),
    .a(l1_a), .b(l1_b), .res(mul_res), .flags(mul_flags), .valid(mul_valid));

endmodule

//--- test/exu_cluster_tb.sv
module exu_cluster_tb import exu_cfg_pkg::*, exu_op_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int data_w       = 64;
  localparam int clk_period   = 4;
  localparam int reset_cycles = 10;
  localparam int n_ops        = 4000;
  localparam int burst_every  = 200; // Each period opens with a run of back-to-back multiplies
  localparam int burst_len    = 12;
  localparam int watchdog_ns  = (reset_cycles + n_ops + 64) * clk_period + 1000;

  logic              clk;
  logic              arst_n;
  logic              flush;
  logic              lane0_valid, lane1_valid;
  op_t               lane0_op, lane1_op;
  logic [data_w-1:0] lane0_a, lane0_b, lane1_a, lane1_b;
  flags_t            lane0_flags_in, lane1_flags_in;
  byp_src_t          lane0_a_src, lane0_b_src, lane0_f_src;
  byp_src_t          lane1_a_src, lane1_b_src, lane1_f_src;
  logic [data_w-1:0] lane0_res, lane1_res, mul_res;
  flags_t            lane0_flags, lane1_flags, mul_flags;
  logic              lane0_res_valid, lane1_res_valid, mul_valid;

  // Bus mirrors, index 0 lane 0, 1 lane 1, 2 multiplier (same order as byp_src_t minus one)
  logic [data_w-1:0] m_res [3];
  flags_t            m_flg [3];
  logic              m_vld [3];
  logic              pend_v [2]; // Lane results due at the next edge
  logic [data_w-1:0] pend_res [2];
  flags_t            pend_flg [2];
  logic              mul_pend [3];
  logic [data_w-1:0] mul_pres [3];
  flags_t            mul_pflg [3];
  logic [63:0]       shift_seen;
  int                mul_done;
  int                seed = 32'hac2b8c15;

  exu_cluster #(.data_w(data_w)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired before the test sequence finished");
    $display("TEST FAIL");
    $fatal(1, "Simulation timed out");
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Output mismatch");
    end
  endtask

  function automatic logic [data_w-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic byp_src_t pick_src();
    return byp_src_t'($unsigned($random(seed)) % 4);
  endfunction

  function automatic logic [data_w-1:0] pick_data(byp_src_t src, logic [data_w-1:0] port);
    return (src == src_port) ? port : m_res[src - 1];
  endfunction

  function automatic flags_t pick_flags(byp_src_t src, flags_t port);
    return (src == src_port) ? port : m_flg[src - 1];
  endfunction

  // Expected result straight from the operation definitions
  task automatic ref_exec(input op_t op, input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                          input flags_t fin, output logic [data_w-1:0] r, output flags_t f);
    logic [data_w:0] wide;
    f = '0;
    case (op)
      op_add, op_adc: begin
        wide = {1'b0, a} + {1'b0, b} + {{data_w{1'b0}}, (op == op_adc) & fin.carry};
        r = wide[data_w-1:0];
        f.carry = wide[data_w];
        f.ovf = (a[data_w-1] == b[data_w-1]) && (r[data_w-1] != a[data_w-1]);
      end
      op_sub: begin
        r = a - b;
        f.carry = (a >= b); // Set when there is no borrow
        f.ovf = (a[data_w-1] != b[data_w-1]) && (r[data_w-1] != a[data_w-1]);
      end
      op_and:  r = a & b;
      op_or:   r = a | b;
      op_xor:  r = a ^ b;
      op_shl:  r = a << b[5:0];
      op_shr:  r = a >> b[5:0];
      op_sar:  r = $signed(a) >>> b[5:0];
      op_mul:  r = a * b;
      default: r = '0;
    endcase
    f.zero = (r == '0);
    f.sign = r[data_w-1];
  endtask

  // Runs at the falling edge and applies what the rising edge just did
  task automatic step_model();
    logic [data_w-1:0] a0, b0, a1, b1, r0, r1;
    flags_t            f0, f1, q0, q1;
    logic              go0, go1, go_mul;
    if (!arst_n) begin
      for (int k = 0; k < 3; k++) begin
        m_res[k]    = '0;
        m_flg[k]    = '0;
        m_vld[k]    = 1'b0;
        mul_pend[k] = 1'b0;
      end
      pend_v[0] = 1'b0;
      pend_v[1] = 1'b0;
    end else begin
      a0 = pick_data(lane0_a_src, lane0_a); // Buses as they stood before this edge
      b0 = pick_data(lane0_b_src, lane0_b);
      f0 = pick_flags(lane0_f_src, lane0_flags_in);
      a1 = pick_data(lane1_a_src, lane1_a);
      b1 = pick_data(lane1_b_src, lane1_b);
      f1 = pick_flags(lane1_f_src, lane1_flags_in);
      ref_exec(lane0_op, a0, b0, f0, r0, q0);
      ref_exec(lane1_op, a1, b1, f1, r1, q1);
      go0    = lane0_valid && !flush;
      go1    = lane1_valid && !flush && (lane1_op != op_mul);
      go_mul = lane1_valid && !flush && (lane1_op == op_mul);
      for (int k = 0; k < 2; k++) begin
        m_vld[k] = pend_v[k] && !flush;
        if (m_vld[k]) begin
          m_res[k] = pend_res[k];
          m_flg[k] = pend_flg[k];
        end
      end
      m_vld[2] = mul_pend[2] && !flush;
      if (m_vld[2]) begin
        m_res[2] = mul_pres[2];
        m_flg[2] = mul_pflg[2];
        mul_done++;
      end
      for (int k = 2; k > 0; k--) begin
        mul_pend[k] = mul_pend[k-1] && !flush;
        mul_pres[k] = mul_pres[k-1];
        mul_pflg[k] = mul_pflg[k-1];
      end
      mul_pend[0] = go_mul;
      mul_pres[0] = r1;
      mul_pflg[0] = q1;
      pend_v[0]   = go0;
      pend_res[0] = r0;
      pend_flg[0] = q0;
      pend_v[1]   = go1;
      pend_res[1] = r1;
      pend_flg[1] = q1;
      if (go1 && (lane1_op inside {op_shl, op_shr, op_sar})) begin
        shift_seen[b1[5:0]] = 1'b1;
      end
    end
  endtask

  task automatic compare_outputs();
    check_val("lane0_res_valid", lane0_res_valid, m_vld[0]);
    check_val("lane0_res", lane0_res, m_res[0]);
    check_val("lane0_flags", lane0_flags, m_flg[0]);
    check_val("lane1_res_valid", lane1_res_valid, m_vld[1]);
    check_val("lane1_res", lane1_res, m_res[1]);
    check_val("lane1_flags", lane1_flags, m_flg[1]);
    check_val("mul_valid", mul_valid, m_vld[2]);
    check_val("mul_res", mul_res, m_res[2]);
    check_val("mul_flags", mul_flags, m_flg[2]);
  endtask

  task automatic run_cycle();
    @(negedge clk);
    step_model();
    compare_outputs();
  endtask

  task automatic drive_random(input int i);
    logic        burst;
    logic [31:0] r;
    burst = (i % burst_every) < burst_len;
    flush = burst ? (i % burst_every == burst_len / 2) : ($unsigned($random(seed)) % 40 == 0);
    lane0_valid = ($unsigned($random(seed)) % 4) != 0;
    lane0_op    = op_t'($unsigned($random(seed)) % 6); // ALU ops only on lane 0
    lane0_a     = rand64();
    lane0_b     = ($unsigned($random(seed)) % 8 == 0) ? lane0_a : rand64();
    r           = $random(seed);
    lane0_flags_in = r[3:0];
    lane0_a_src = pick_src();
    lane0_b_src = pick_src();
    lane0_f_src = pick_src();
    lane1_valid = burst || (($unsigned($random(seed)) % 4) != 0);
    lane1_op    = burst ? op_mul : op_t'($unsigned($random(seed)) % 10);
    lane1_a     = rand64();
    lane1_b     = ($unsigned($random(seed)) % 8 == 0) ? lane1_a : rand64();
    r           = $random(seed);
    lane1_flags_in = r[3:0];
    lane1_a_src = pick_src();
    lane1_b_src = pick_src();
    lane1_f_src = pick_src();
  endtask

  initial begin
    arst_n         = 1'b0;
    flush          = 1'b0;
    lane0_valid    = 1'b0;
    lane1_valid    = 1'b0;
    lane0_op       = op_add;
    lane1_op       = op_add;
    lane0_a        = '0;
    lane0_b        = '0;
    lane1_a        = '0;
    lane1_b        = '0;
    lane0_flags_in = '0;
    lane1_flags_in = '0;
    lane0_a_src    = src_port;
    lane0_b_src    = src_port;
    lane0_f_src    = src_port;
    lane1_a_src    = src_port;
    lane1_b_src    = src_port;
    lane1_f_src    = src_port;
    shift_seen     = '0;
    mul_done       = 0;
    repeat (reset_cycles) run_cycle();
    arst_n = 1'b1;
    for (int i = 0; i < n_ops; i++) begin
      drive_random(i);
      run_cycle();
    end
    lane0_valid = 1'b0;
    lane1_valid = 1'b0;
    flush       = 1'b0;
    while (pend_v[0] || pend_v[1] || mul_pend[0] || mul_pend[1] || mul_pend[2]) begin
      run_cycle();
    end
    repeat (4) run_cycle(); // Idle buses must stay quiet
    if (mul_done == 0 || shift_seen != '1) begin
      $display("Stimulus never reached every shift amount or never completed a multiply");
      $display("TEST FAIL");
      $fatal(1, "Incomplete stimulus");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- sources.f
logic/exu_cfg_pkg.sv
logic/exu_op_pkg.sv
logic/operand_bypass.sv
logic/barrel_shifter.sv
logic/int_alu.sv
logic/pipe_multiplier.sv
logic/exu_control.sv
logic/exu_cluster.sv
test/exu_cluster_tb.sv
